/* bench/canvas_patterns.hex */
// Each line holds bit count, check flag and command word in hex
// A set flag checks the picture afterwards and count 00 ends the list
18 1 0200123
18 1 0153F00
18 1 01FB0F0
17 0 0400ABC
19 0 1200ABC
18 1 0000FFF
18 0 020000F
18 0 0100888
18 0 01A6FF0
18 1 0200321
00 0 0000000

/* bench/pixel_canvas_tb.sv */
`timescale 1ns/1ns

module pixel_canvas_tb;

    localparam int FRAME_CLOCKS = 1120;
    localparam int LINE_CLOCKS  = 40;
    localparam int MAX_PATTERNS = 16;
    localparam int NUM_RANDOM   = 4;

    logic        clk_system = 1'b0;
    logic        rstn_system;
    logic        spi_sclk;
    logic        spi_ssn;
    logic        spi_mosi;
    logic        spi_miso;
    logic        vga_hsync;
    logic        vga_vsync;
    logic [3:0]  vga_red;
    logic [3:0]  vga_green;
    logic [3:0]  vga_blue;

    logic [31:0] pat_mem [3*MAX_PATTERNS];
    int          n_pat = 0;
    int          watchdog_clocks = 0;
    int          cycle = 0;
    int          last_hrise = -1;
    int          last_vfall = -1;
    int          vfall_count = 0;
    logic        hsync_prev = 1'b1;
    logic        vsync_prev = 1'b1;

    // Settings register model and the word miso should echo
    int          m_x = 0;
    int          m_y = 0;
    logic [11:0] m_spot = '0;
    logic [11:0] m_bg = '0;
    logic [23:0] last_word = '0;

    pixel_canvas_top pixel_canvas_top_i (
        .clk_system (clk_system),
        .rstn_system(rstn_system),
        .spi_sclk   (spi_sclk),
        .spi_ssn    (spi_ssn),
        .spi_mosi   (spi_mosi),
        .spi_miso   (spi_miso),
        .vga_hsync  (vga_hsync),
        .vga_vsync  (vga_vsync),
        .vga_red    (vga_red),
        .vga_green  (vga_green),
        .vga_blue   (vga_blue)
    );

    always #20 clk_system = ~clk_system;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            stop_with_failure($sformatf("[FAIL] time %0t ns: %s is %h, expected %h",
                                        $time, name, got, want));
        end
    endtask

    task automatic tick(input int n);
        repeat (n) @(posedge clk_system);
        #5;
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Spot covers x..x+1 and y..y+1 and is cut off at the buffer edge
    function automatic logic [11:0] expected_pixel(input int bx, input int by);
        if ((bx == m_x || bx == m_x + 1) && (by == m_y || by == m_y + 1)) begin
            return m_spot;
        end
        return m_bg;
    endfunction

    task automatic apply_command(input logic [23:0] word);
        case (word[23:20])
            4'h1: begin
                m_x    = word[19:16];
                m_y    = word[15:12];
                m_spot = word[11:0];
            end
            4'h2: m_bg = word[11:0];
            default: ;
        endcase
    endtask

    ////////////////////////////////////////
    // SPI master in mode 0 with MSB first

    task automatic spi_send(input int nbits, input logic [31:0] word,
                            output logic [31:0] seen);
        int i;
        seen = '0;
        tick(1);
        spi_ssn = 1'b0;
        for (i = nbits - 1; i >= 0; i--) begin
            spi_mosi = word[i];
            tick(4);
            seen = {seen[30:0], spi_miso};
            spi_sclk = 1'b1;
            tick(4);
            spi_sclk = 1'b0;
        end
        tick(4);
        spi_ssn = 1'b1;
        // Leaves room for the command pulse behind the synchronisers
        tick(4);
    endtask

    task automatic run_transfer(input int nbits, input logic [31:0] word);
        logic [31:0] seen;
        spi_send(nbits, word, seen);
        if (nbits == 24) begin
            check_value("spi_miso echo word", seen, {8'h00, last_word});
            last_word = word[23:0];
            apply_command(word[23:0]);
        end
    endtask

    ////////////////////////////////////////
    // Sync period monitor and frame checker

    always @(negedge clk_system) begin
        if (rstn_system) begin
            cycle++;
            if (vga_hsync && !hsync_prev) begin
                if (last_hrise >= 0) begin
                    check_value("vga_hsync period", cycle - last_hrise, LINE_CLOCKS);
                end
                last_hrise = cycle;
            end
            if (!vga_vsync && vsync_prev) begin
                if (last_vfall >= 0) begin
                    check_value("vga_vsync period", cycle - last_vfall, FRAME_CLOCKS);
                end
                last_vfall = cycle;
                vfall_count++;
            end
        end
        hsync_prev = vga_hsync;
        vsync_prev = vga_vsync;
    end

    task automatic wait_vsync_falls(input int n);
        int target;
        target = vfall_count + n;
        wait (vfall_count >= target);
    endtask

    task automatic blank_until_hsync_rise();
        logic prev;
        do begin
            check_value("blanking colour", {vga_red, vga_green, vga_blue}, 0);
            prev = vga_hsync;
            @(negedge clk_system);
        end while (!(vga_hsync && !prev));
    endtask

    task automatic check_next_frame();
        int row;
        int col;
        wait_vsync_falls(1);
        // Two sync lines and the back-porch line
        repeat (3) blank_until_hsync_rise();
        for (row = 0; row < 24; row++) begin
            repeat (2) begin
                check_value("back porch colour", {vga_red, vga_green, vga_blue}, 0);
                @(negedge clk_system);
            end
            for (col = 0; col < 32; col++) begin
                check_value($sformatf("colour at row %0d col %0d", row, col),
                            {vga_red, vga_green, vga_blue},
                            expected_pixel(col / 2, row / 2));
                @(negedge clk_system);
            end
            blank_until_hsync_rise();
        end
    endtask

    task automatic load_patterns();
        $readmemh("bench/canvas_patterns.hex", pat_mem);
        while (n_pat < MAX_PATTERNS && !$isunknown(pat_mem[3*n_pat]) &&
               pat_mem[3*n_pat] != 0) begin
            n_pat++;
        end
        if (n_pat == 0) begin
            stop_with_failure("The pattern file bench/canvas_patterns.hex is missing or empty");
        end
    endtask

    // Watchdog
    initial begin
        wait (watchdog_clocks > 0);
        repeat (watchdog_clocks) @(posedge clk_system);
        stop_with_failure("Timeout: the tests did not finish within the expected frames");
    end

    initial begin
        int          i;
        logic [31:0] rnd;
        logic [31:0] word;
        logic [3:0]  op;
        rstn_system = 1'b0;
        spi_sclk    = 1'b0;
        spi_ssn     = 1'b1;
        spi_mosi    = 1'b0;
        rnd         = 32'h9281_c2d2;
        load_patterns();
        watchdog_clocks = (n_pat + NUM_RANDOM + 4) * 3 * FRAME_CLOCKS;

        @(negedge clk_system);
        check_value("vga_hsync in reset", vga_hsync, 1);
        check_value("vga_vsync in reset", vga_vsync, 1);
        check_value("colour in reset", {vga_red, vga_green, vga_blue}, 0);
        tick(2);
        rstn_system = 1'b1;

        // First swap brings in the all-black reset paint
        wait_vsync_falls(1);
        check_next_frame();

        for (i = 0; i < n_pat; i++) begin
            run_transfer(pat_mem[3*i], pat_mem[3*i+2]);
            if (pat_mem[3*i+1] != 0) begin
                wait_vsync_falls(2);
                check_next_frame();
            end
        end

        for (i = 0; i < NUM_RANDOM; i++) begin
            rnd  = xorshift(rnd);
            op   = (rnd[21:20] == 2'd3) ? 4'h1 : {2'b00, rnd[21:20]};
            word = {8'h00, op, rnd[19:0]};
            run_transfer(24, word);
            wait_vsync_falls(2);
            check_next_frame();
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* filelist.f */
hw/video_pkg.sv
hw/draw_pkg.sv
hw/spi_cmd_rx.sv
hw/frame_painter.sv
hw/frame_buffer_pair.sv
hw/raster_scanner.sv
hw/pixel_canvas_top.sv
bench/pixel_canvas_tb.sv

/* hw/draw_pkg.sv */
package draw_pkg;

    typedef enum logic [3:0] {
        CMD_NOP            = 4'h0,
        CMD_SET_SPOT       = 4'h1,
        CMD_SET_BACKGROUND = 4'h2
    } cmd_op_t;

    // 24-bit SPI word, op in the top nibble
    typedef struct packed {
        cmd_op_t           op;
        logic [3:0]        x;
        logic [3:0]        y;
        video_pkg::pixel_t color;
    } spot_cmd_t;

    typedef enum logic [1:0] {
        PAINT_IDLE,
        PAINT_FILL,
        PAINT_DONE
    } paint_state_t;

    // One write into the hidden buffer
    typedef struct packed {
        logic                 en;
        video_pkg::buf_addr_t addr;
        video_pkg::pixel_t    color;
    } buf_write_t;

endpackage

/* hw/frame_buffer_pair.sv */
`timescale 1ns/1ns

module frame_buffer_pair #(
    parameter int WIDTH  = 16,
    parameter int HEIGHT = 12
) (
    input  logic                 clk_system,
    input  logic                 rstn_system,
    input  draw_pkg::buf_write_t wr,
    input  logic                 frame_done,
    input  logic                 vsync_start,
    input  video_pkg::buf_addr_t rd_addr,
    output video_pkg::pixel_t    rd_pixel,
    output logic                 swapped
);
    localparam int DEPTH = WIDTH * HEIGHT;

    logic              front_sel;
    logic              rd_sel;
    logic              swap_now;
    video_pkg::pixel_t bank_q [2];

    // Swap only at the start of vsync, and only with a finished picture
    assign swap_now = vsync_start && frame_done;
    assign swapped  = swap_now;

    always_ff @(posedge clk_system or negedge rstn_system) begin
        if (!rstn_system) begin
            front_sel <= 1'b0;
            rd_sel    <= 1'b0;
        end else begin
            if (swap_now) begin
                front_sel <= ~front_sel;
            end
            // Bank that served the read issued last clock
            rd_sel <= front_sel;
        end
    end

    ////////////////////////////////////////
    // Two banks, write to back, read both

    for (genvar b = 0; b < 2; b++) begin : g_bank
        video_pkg::pixel_t mem [DEPTH];
        logic              we;

        assign we = wr.en && (front_sel != 1'(b));

        always_ff @(posedge clk_system) begin
            if (we) begin
                mem[wr.addr] <= wr.color;
            end
            bank_q[b] <= mem[rd_addr];
        end
    end

    assign rd_pixel = bank_q[rd_sel];

endmodule

/* hw/frame_painter.sv */
`timescale 1ns/1ns

module frame_painter #(
    parameter int WIDTH  = 16,
    parameter int HEIGHT = 12
) (
    input  logic                 clk_system,
    input  logic                 rstn_system,
    input  logic                 cmd_valid,
    input  draw_pkg::spot_cmd_t  cmd,
    input  logic                 swapped,
    output draw_pkg::buf_write_t wr,
    output logic                 frame_done
);
    localparam int COL_W = $clog2(WIDTH);
    localparam int ROW_W = $clog2(HEIGHT);

    typedef struct packed {
        logic [3:0]        x;
        logic [3:0]        y;
        video_pkg::pixel_t spot;
        video_pkg::pixel_t bg;
    } paint_settings_t;

    draw_pkg::paint_state_t state;
    paint_settings_t        settings;
    paint_settings_t        work;
    logic [COL_W-1:0]       col;
    logic [ROW_W-1:0]       row;
    logic                   start_paint;
    logic                   last_col;
    logic                   last_row;
    logic                   in_spot;

    assign start_paint = (state == draw_pkg::PAINT_IDLE) ||
                         ((state == draw_pkg::PAINT_DONE) && swapped);
    assign last_col    = (col == COL_W'(WIDTH - 1));
    assign last_row    = (row == ROW_W'(HEIGHT - 1));

    // Settings from the command stream, picked up at the next paint
    always_ff @(posedge clk_system or negedge rstn_system) begin
        if (!rstn_system) begin
            settings <= '0;
        end else if (cmd_valid) begin
            case (cmd.op)
                draw_pkg::CMD_SET_SPOT: begin
                    settings.x    <= cmd.x;
                    settings.y    <= cmd.y;
                    settings.spot <= cmd.color;
                end
                draw_pkg::CMD_SET_BACKGROUND: settings.bg <= cmd.color;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_system) begin
        if (start_paint) begin
            work <= settings;
        end
    end

    ////////////////////////////////////////
    // Paint FSM, one pixel per clock

    always_ff @(posedge clk_system or negedge rstn_system) begin
        if (!rstn_system) begin
            state <= draw_pkg::PAINT_IDLE;
            col   <= '0;
            row   <= '0;
        end else if (start_paint) begin
            state <= draw_pkg::PAINT_FILL;
            col   <= '0;
            row   <= '0;
        end else if (state == draw_pkg::PAINT_FILL) begin
            if (last_col) begin
                col <= '0;
                if (last_row) begin
                    state <= draw_pkg::PAINT_DONE;
                end else begin
                    row <= row + 1'b1;
                end
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    // Spot covers x..x+1 and y..y+1, clipped by the walk itself
    assign in_spot = ((int'(col) == int'(work.x)) || (int'(col) == int'(work.x) + 1)) &&
                     ((int'(row) == int'(work.y)) || (int'(row) == int'(work.y) + 1));

    always_comb begin
        wr.en    = (state == draw_pkg::PAINT_FILL);
        wr.addr  = video_pkg::buf_addr_t'(int'(row) * WIDTH + int'(col));
        wr.color = in_spot ? work.spot : work.bg;
    end

    assign frame_done = (state == draw_pkg::PAINT_DONE);

endmodule

/* hw/pixel_canvas_top.sv */
`timescale 1ns/1ns

module pixel_canvas_top (
    input  logic       clk_system,
    input  logic       rstn_system,
    input  logic       spi_sclk,
    input  logic       spi_ssn,
    input  logic       spi_mosi,
    output logic       spi_miso,
    output logic       vga_hsync,
    output logic       vga_vsync,
    output logic [3:0] vga_red,
    output logic [3:0] vga_green,
    output logic [3:0] vga_blue
);
    localparam video_pkg::video_mode_t MODE = video_pkg::video_mode_sim;
    localparam int WIDTH  = video_pkg::BUF_WIDTH;
    localparam int HEIGHT = video_pkg::BUF_HEIGHT;

    logic                 cmd_valid;
    draw_pkg::spot_cmd_t  cmd;
    draw_pkg::buf_write_t wr;
    logic                 frame_done;
    logic                 swapped;
    logic                 vsync_start;
    video_pkg::buf_addr_t rd_addr;
    video_pkg::pixel_t    rd_pixel;
    video_pkg::pixel_t    color;

    ////////////////////////////////////////
    // Command input

    spi_cmd_rx spi_cmd_rx_i (
        .clk_system (clk_system),
        .rstn_system(rstn_system),
        .spi_sclk   (spi_sclk),
        .spi_ssn    (spi_ssn),
        .spi_mosi   (spi_mosi),
        .spi_miso   (spi_miso),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd)
    );

    ////////////////////////////////////////
    // Painting and buffers

    frame_painter #(
        .WIDTH (WIDTH),
        .HEIGHT(HEIGHT)
    ) frame_painter_i (
        .clk_system (clk_system),
        .rstn_system(rstn_system),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .swapped    (swapped),
        .wr         (wr),
        .frame_done (frame_done)
    );

    frame_buffer_pair #(
        .WIDTH (WIDTH),
        .HEIGHT(HEIGHT)
    ) frame_buffer_pair_i (
        .clk_system (clk_system),
        .rstn_system(rstn_system),
        .wr         (wr),
        .frame_done (frame_done),
        .vsync_start(vsync_start),
        .rd_addr    (rd_addr),
        .rd_pixel   (rd_pixel),
        .swapped    (swapped)
    );

    ////////////////////////////////////////
    // Display output

    raster_scanner #(
        .MODE(MODE)
    ) raster_scanner_i (
        .clk_system (clk_system),
        .rstn_system(rstn_system),
        .rd_addr    (rd_addr),
        .rd_pixel   (rd_pixel),
        .vsync_start(vsync_start),
        .hsync      (vga_hsync),
        .vsync      (vga_vsync),
        .color      (color)
    );

    assign vga_red   = color.red;
    assign vga_green = color.green;
    assign vga_blue  = color.blue;

endmodule

/* hw/raster_scanner.sv */
`timescale 1ns/1ns

module raster_scanner #(
    parameter video_pkg::video_mode_t MODE = video_pkg::video_mode_sim
) (
    input  logic                 clk_system,
    input  logic                 rstn_system,
    output video_pkg::buf_addr_t rd_addr,
    input  video_pkg::pixel_t    rd_pixel,
    output logic                 vsync_start,
    output logic                 hsync,
    output logic                 vsync,
    output video_pkg::pixel_t    color
);
    localparam int H_TOTAL    = MODE.h_active + MODE.h_front + MODE.h_sync + MODE.h_back;
    localparam int V_TOTAL    = MODE.v_active + MODE.v_front + MODE.v_sync + MODE.v_back;
    localparam int H_SYNC_ON  = MODE.h_active + MODE.h_front;
    localparam int H_SYNC_OFF = H_SYNC_ON + MODE.h_sync;
    localparam int V_SYNC_ON  = MODE.v_active + MODE.v_front;
    localparam int V_SYNC_OFF = V_SYNC_ON + MODE.v_sync;
    localparam int BUF_W      = MODE.h_active / MODE.scale;
    localparam int HW         = $clog2(H_TOTAL);
    localparam int VW         = $clog2(V_TOTAL);

    logic [HW-1:0] h_count;
    logic [VW-1:0] v_count;
    logic          active0;
    logic          hsync0;
    logic          vsync0;
    logic          active1;
    logic          hsync1;
    logic          vsync1;
    logic          hsync2;
    logic          vsync2;

    // Line: active, front porch, sync, back porch
    always_ff @(posedge clk_system or negedge rstn_system) begin
        if (!rstn_system) begin
            h_count <= '0;
            v_count <= '0;
        end else if (h_count == HW'(H_TOTAL - 1)) begin
            h_count <= '0;
            if (v_count == VW'(V_TOTAL - 1)) begin
                v_count <= '0;
            end else begin
                v_count <= v_count + 1'b1;
            end
        end else begin
            h_count <= h_count + 1'b1;
        end
    end

    assign active0 = (h_count < MODE.h_active) && (v_count < MODE.v_active);
    assign hsync0  = (h_count >= H_SYNC_ON) && (h_count < H_SYNC_OFF);
    assign vsync0  = (v_count >= V_SYNC_ON) && (v_count < V_SYNC_OFF);

    // Scaled position into the buffer, parked at 0 while blanking
    assign rd_addr = active0 ?
        video_pkg::buf_addr_t'((v_count / MODE.scale) * BUF_W + h_count / MODE.scale) : '0;

    ////////////////////////////////////////
    // Two-stage alignment with the pixel

    always_ff @(posedge clk_system or negedge rstn_system) begin
        if (!rstn_system) begin
            active1     <= 1'b0;
            hsync1      <= 1'b0;
            vsync1      <= 1'b0;
            hsync2      <= 1'b0;
            vsync2      <= 1'b0;
            vsync_start <= 1'b0;
            color       <= '0;
        end else begin
            active1     <= active0;
            hsync1      <= hsync0;
            vsync1      <= vsync0;
            hsync2      <= hsync1;
            vsync2      <= vsync1;
            vsync_start <= vsync1 & ~vsync2;
            color       <= active1 ? rd_pixel : '0;
        end
    end

    // Internal flags are active high
    assign hsync = MODE.sync_pol ? hsync2 : ~hsync2;
    assign vsync = MODE.sync_pol ? vsync2 : ~vsync2;

endmodule

/* hw/spi_cmd_rx.sv */
`timescale 1ns/1ns

module spi_cmd_rx (
    input  logic                clk_system,
    input  logic                rstn_system,
    input  logic                spi_sclk,
    input  logic                spi_ssn,
    input  logic                spi_mosi,
    output logic                spi_miso,
    output logic                cmd_valid,
    output draw_pkg::spot_cmd_t cmd
);
    // [0] first flop, [1] synchronised, [2] previous value for edges
    logic [2:0]  sclk_sync;
    logic [2:0]  ssn_sync;
    logic [1:0]  mosi_sync;
    logic        sclk_rise;
    logic        sclk_fall;
    logic        ssn_rise;
    logic        ssn_fall;
    logic        ssn_low;
    logic [23:0] rx_shift;
    logic [4:0]  bit_count;
    logic [23:0] echo;
    logic [23:0] tx_shift;

    always_ff @(posedge clk_system or negedge rstn_system) begin
        if (!rstn_system) begin
            sclk_sync <= 3'b000;
            ssn_sync  <= 3'b111;
            mosi_sync <= 2'b00;
        end else begin
            sclk_sync <= {sclk_sync[1:0], spi_sclk};
            ssn_sync  <= {ssn_sync[1:0], spi_ssn};
            mosi_sync <= {mosi_sync[0], spi_mosi};
        end
    end

    assign sclk_rise = sclk_sync[1] & ~sclk_sync[2];
    assign sclk_fall = ~sclk_sync[1] & sclk_sync[2];
    assign ssn_rise  = ssn_sync[1] & ~ssn_sync[2];
    assign ssn_fall  = ~ssn_sync[1] & ssn_sync[2];
    assign ssn_low   = ~ssn_sync[1];

    ////////////////////////////////////////
    // Receive side, MSB first

    always_ff @(posedge clk_system or negedge rstn_system) begin
        if (!rstn_system) begin
            rx_shift  <= '0;
            bit_count <= '0;
            cmd_valid <= 1'b0;
            echo      <= '0;
        end else begin
            if (ssn_fall) begin
                bit_count <= '0;
            end else if (sclk_rise && ssn_low) begin
                rx_shift <= {rx_shift[22:0], mosi_sync[1]};
                // Saturate so that long transfers never wrap back to 24
                if (bit_count != 5'd31) begin
                    bit_count <= bit_count + 5'd1;
                end
            end
            cmd_valid <= ssn_rise && (bit_count == 5'd24);
            if (ssn_rise && (bit_count == 5'd24)) begin
                echo <= rx_shift;
            end
        end
    end

    assign cmd = draw_pkg::spot_cmd_t'(echo);

    ////////////////////////////////////////
    // Echo side, last accepted word

    always_ff @(posedge clk_system or negedge rstn_system) begin
        if (!rstn_system) begin
            tx_shift <= '0;
        end else if (ssn_fall) begin
            tx_shift <= echo;
        end else if (sclk_fall && ssn_low) begin
            tx_shift <= {tx_shift[22:0], 1'b0};
        end
    end

    assign spi_miso = tx_shift[23];

endmodule

/* hw/video_pkg.sv */
package video_pkg;

    // Line and frame layout of one display mode
    typedef struct packed {
        int unsigned h_active;
        int unsigned h_front;
        int unsigned h_sync;
        int unsigned h_back;
        int unsigned v_active;
        int unsigned v_front;
        int unsigned v_sync;
        int unsigned v_back;
        bit          sync_pol;  // 1 means active-high syncs
        int unsigned scale;
    } video_mode_t;

    // Same shape as 640x480, shrunk to 40 clocks per line and 28 lines
    localparam video_mode_t video_mode_sim = '{
        h_active: 32,
        h_front:  2,
        h_sync:   4,
        h_back:   2,
        v_active: 24,
        v_front:  1,
        v_sync:   2,
        v_back:   1,
        sync_pol: 1'b0,
        scale:    2
    };

    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } pixel_t;

    localparam int BUF_WIDTH  = 16;
    localparam int BUF_HEIGHT = 12;

    // Row * 16 + column
    typedef logic [7:0] buf_addr_t;

endpackage
